// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dma_path
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
src/dma_path_pkg.sv
src/sync_fifo.sv
src/token_arbiter.sv
src/msg_intake.sv
src/cmd_dispatch.sv
src/dma_path_top.sv
testbench/tb_dma_path.sv

// ==== src/cmd_dispatch.sv ====
//////////////////////////////////////////////////////////////////////
// pops messages from the message fifo and routes them by form
// reads go to the rcc fifo and writes stream length-1 data beats on wcc
// unknown forms are dropped
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cmd_dispatch import dma_path_pkg::*; (
	input  logic         fpu_clk,
	input  logic         reset,
	input  logic [127:0] msg_head,
	input  logic         msg_empty,
	output logic         msg_pop,
	output logic         rcc_push,
	input  logic         rcc_full,
	output dma_cmd_t     wcc_cmd,
	output logic [127:0] wcc_write_data,
	output logic         wcc_valid,
	input  logic         wcc_ready
);

	dispatch_state_e state;
	dma_hdr_t        head_hdr;
	logic            is_read;
	logic            is_write;
	logic [15:0]     beats_left;    // data beats still owed on wcc
	logic            wcc_xfer;

	assign head_hdr = dma_hdr_t'(msg_head);
	assign is_read  = (head_hdr.msg_form == MSG_READ);
	assign is_write = (head_hdr.msg_form == MSG_WRITE);

	//////////////////////////////////////////////////////////////////////
	// fifo side
	//////////////////////////////////////////////////////////////////////
	assign wcc_write_data = msg_head;
	assign wcc_valid      = (state == DC_WRITE) && !msg_empty;
	assign wcc_xfer       = wcc_valid && wcc_ready;
	assign rcc_push       = (state == DC_IDLE) && !msg_empty && is_read && !rcc_full;

	// headers leave in idle and data beats only on a wcc transfer
	assign msg_pop = (state == DC_WRITE) ? wcc_xfer :
	                 (!msg_empty && (!is_read || !rcc_full));

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state      <= DC_IDLE;
			beats_left <= 16'd0;
		end else begin
			case (state)
				DC_IDLE: begin
					// single-beat write has nothing to send
					if (!msg_empty && is_write && head_hdr.length > 16'd1) begin
						beats_left <= head_hdr.length - 16'd1;
						state      <= DC_WRITE;
					end
				end
				DC_WRITE: begin
					if (wcc_xfer) begin
						beats_left <= beats_left - 16'd1;
						if (beats_left == 16'd1)
							state <= DC_IDLE;
					end
				end
				default: state <= DC_IDLE;
			endcase
		end
	end

	// command register for the write controller
	always_ff @(posedge fpu_clk) begin
		if (state == DC_IDLE && msg_pop && is_write)
			wcc_cmd <= dma_cmd_t'(msg_head[71:0]);
	end

	// no pop while stalled so the fifo head must stay put
	a_wcc_valid_held: assert property (@(posedge fpu_clk) disable iff (reset)
		(wcc_valid && !wcc_ready) |=> (wcc_valid && $stable(wcc_write_data)))
		else $error("wcc beat lost under back-pressure");

endmodule

// ==== src/dma_path_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types for the fpu side dma path, single clock (fpu_clk)
// header and command layouts match the dram controller command word
//////////////////////////////////////////////////////////////////////

package dma_path_pkg;

	// fixed, the arbiter is written for ports a to d
	localparam int NUM_PORTS = 4;

	// message form byte of the header
	typedef enum logic [7:0] {
		MSG_READ  = 8'h01,
		MSG_WRITE = 8'h03
	} msg_form_e;

	// 128 bit header beat, length counts the header itself
	typedef struct packed {
		logic [47:0] pad;
		msg_form_e   msg_form;
		logic [15:0] length;
		logic [15:0] dpram_addr;
		logic [39:0] dram_addr;
	} dma_hdr_t;

	// low 72 bits of the header as seen by the dram controllers
	typedef struct packed {
		logic [15:0] length;
		logic [15:0] dpram_addr;
		logic [39:0] dram_addr;
	} dma_cmd_t;

	// one fpu write beat
	typedef struct packed {
		logic         valid;
		logic [127:0] data;
	} fpu_wr_t;

	typedef enum logic {ARB_SCAN, ARB_HOLD} arb_state_e;
	typedef enum logic [1:0] {IN_IDLE, IN_HEADER, IN_BODY} intake_state_e;
	typedef enum logic {DC_IDLE, DC_WRITE} dispatch_state_e;

endpackage

// ==== src/dma_path_top.sv ====
//////////////////////////////////////////////////////////////////////
// fpu side dma path: four ports share one message path
// rcc_valid is high only while rcc_ready is high (consumed same cycle)
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_path_top import dma_path_pkg::*; #(
	parameter int MSG_FIFO_DEPTH = 16,
	parameter int RCC_FIFO_DEPTH = 4
) (
	input  logic                 fpu_clk,
	input  logic                 reset,
	input  logic [NUM_PORTS-1:0] dma_req,
	output logic [NUM_PORTS-1:0] dma_resp,
	input  fpu_wr_t              dma_write [NUM_PORTS],
	output logic [NUM_PORTS-1:0] dma_write_ready,
	output dma_cmd_t             rcc_cmd,
	output logic                 rcc_valid,
	input  logic                 rcc_ready,
	output dma_cmd_t             wcc_cmd,
	output logic [127:0]         wcc_write_data,
	output logic                 wcc_valid,
	input  logic                 wcc_ready
);

	logic [NUM_PORTS-1:0] grant;
	logic                 active;
	fpu_wr_t              sel_beat;
	logic                 beat_ready, awaiting_header, msg_done;
	logic                 msg_push, msg_full, msg_pop, msg_empty;
	logic [127:0]         msg_head;
	logic                 rcc_push, rcc_full, rcc_pop, rcc_empty;

	//////////////////////////////////////////////////////////////////////
	// port side muxing
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		sel_beat = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (grant[i])
				sel_beat = dma_write[i];
		end
	end

	assign active          = |grant;
	assign dma_resp        = grant & {NUM_PORTS{awaiting_header}};
	assign dma_write_ready = grant & {NUM_PORTS{beat_ready}};

	token_arbiter u_arb (
		.fpu_clk  (fpu_clk),
		.reset    (reset),
		.dma_req  (dma_req),
		.msg_done (msg_done),
		.grant    (grant)
	);

	msg_intake u_intake (
		.fpu_clk         (fpu_clk),
		.reset           (reset),
		.active          (active),
		.beat            (sel_beat),
		.beat_ready      (beat_ready),
		.awaiting_header (awaiting_header),
		.fifo_full       (msg_full),
		.fifo_push       (msg_push),
		.msg_done        (msg_done)
	);

	sync_fifo #(.WIDTH($bits(dma_hdr_t)), .DEPTH(MSG_FIFO_DEPTH)) msg_fifo (
		.fpu_clk   (fpu_clk),
		.reset     (reset),
		.push      (msg_push),
		.push_data (sel_beat.data),
		.full      (msg_full),
		.pop       (msg_pop),
		.pop_data  (msg_head),
		.empty     (msg_empty)
	);

	cmd_dispatch u_dispatch (
		.fpu_clk        (fpu_clk),
		.reset          (reset),
		.msg_head       (msg_head),
		.msg_empty      (msg_empty),
		.msg_pop        (msg_pop),
		.rcc_push       (rcc_push),
		.rcc_full       (rcc_full),
		.wcc_cmd        (wcc_cmd),
		.wcc_write_data (wcc_write_data),
		.wcc_valid      (wcc_valid),
		.wcc_ready      (wcc_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// read command path
	//////////////////////////////////////////////////////////////////////
	assign rcc_pop   = !rcc_empty && rcc_ready;
	assign rcc_valid = rcc_pop;

	sync_fifo #(.WIDTH($bits(dma_cmd_t)), .DEPTH(RCC_FIFO_DEPTH)) rcc_fifo (
		.fpu_clk   (fpu_clk),
		.reset     (reset),
		.push      (rcc_push),
		.push_data (msg_head[71:0]),   // command part of the read header
		.full      (rcc_full),
		.pop       (rcc_pop),
		.pop_data  (rcc_cmd),
		.empty     (rcc_empty)
	);

endmodule

// ==== src/msg_intake.sv ====
//////////////////////////////////////////////////////////////////////
// takes one message from the granted port into the message fifo
// non-write forms end after the header, writes after length beats
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module msg_intake import dma_path_pkg::*; (
	input  logic    fpu_clk,
	input  logic    reset,
	input  logic    active,
	input  fpu_wr_t beat,
	output logic    beat_ready,
	output logic    awaiting_header,
	input  logic    fifo_full,
	output logic    fifo_push,
	output logic    msg_done
);

	intake_state_e state;
	dma_hdr_t      hdr;
	logic [15:0]   msg_len;
	logic [15:0]   beat_cnt;     // beats taken so far, header included

	assign hdr             = dma_hdr_t'(beat.data);
	assign awaiting_header = (state == IN_HEADER);
	assign beat_ready      = (state == IN_HEADER || state == IN_BODY) && !fifo_full;
	assign fifo_push       = beat.valid && beat_ready;

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= IN_IDLE;
			msg_len  <= 16'd0;
			beat_cnt <= 16'd0;
			msg_done <= 1'b0;
		end else begin
			msg_done <= 1'b0;
			case (state)
				IN_IDLE: begin
					// grant is still up in the msg_done cycle
					if (active && !msg_done)
						state <= IN_HEADER;
				end
				IN_HEADER: begin
					if (fifo_push) begin
						msg_len  <= hdr.length;
						beat_cnt <= 16'd1;
						if (hdr.msg_form != MSG_WRITE || hdr.length <= 16'd1) begin
							msg_done <= 1'b1;
							state    <= IN_IDLE;
						end else begin
							state <= IN_BODY;
						end
					end
				end
				IN_BODY: begin
					if (fifo_push) begin
						beat_cnt <= beat_cnt + 16'd1;
						if (beat_cnt + 16'd1 == msg_len) begin   // last data beat
							msg_done <= 1'b1;
							state    <= IN_IDLE;
						end
					end
				end
				default: state <= IN_IDLE;
			endcase
		end
	end

	a_write_len: assert property (@(posedge fpu_clk) disable iff (reset)
		(state == IN_HEADER && fifo_push && hdr.msg_form == MSG_WRITE)
			|-> hdr.length != 16'd0)
		else $error("write header with zero length");

endmodule

// ==== src/sync_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// single clock fifo, first word fall-through on pop_data
// DEPTH must be a power of two; push when full is not allowed
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 128,
	parameter int DEPTH = 16
) (
	input  logic             fpu_clk,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	output logic             full,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0]      wr_ptr;   // extra msb tells full from empty
	logic [AW:0]      rd_ptr;

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge fpu_clk) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= push_data;
	end

	assign pop_data = mem[rd_ptr[AW-1:0]];   // head word
	assign empty    = (wr_ptr == rd_ptr);
	assign full     = (wr_ptr[AW] != rd_ptr[AW]) &&
	                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	a_no_overflow: assert property (@(posedge fpu_clk) disable iff (reset)
		!(push && full)) else $error("push into full fifo");

	a_no_underflow: assert property (@(posedge fpu_clk) disable iff (reset)
		!(pop && empty)) else $error("pop from empty fifo");

endmodule

// ==== src/token_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// round-robin token for the message path, four ports
// pointer moves only after a grant; grant is held until msg_done
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module token_arbiter import dma_path_pkg::*; (
	input  logic                 fpu_clk,
	input  logic                 reset,
	input  logic [NUM_PORTS-1:0] dma_req,
	input  logic                 msg_done,
	output logic [NUM_PORTS-1:0] grant
);

	arb_state_e  state;
	logic [1:0]  ptr;        // first port to look at
	logic [1:0]  gnt_idx;    // port holding the token
	logic [1:0]  cand;
	logic [1:0]  pick_idx;
	logic        pick_hit;

	//////////////////////////////////////////////////////////////////////
	// pick the first requester at or after ptr
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		pick_hit = 1'b0;
		pick_idx = ptr;
		cand     = ptr;
		for (int i = 0; i < NUM_PORTS; i++) begin
			cand = ptr + 2'(i);
			if (!pick_hit && dma_req[cand]) begin
				pick_hit = 1'b1;
				pick_idx = cand;
			end
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state   <= ARB_SCAN;
			ptr     <= 2'd0;
			gnt_idx <= 2'd0;
			grant   <= '0;
		end else begin
			case (state)
				ARB_SCAN: begin
					if (pick_hit) begin
						grant   <= NUM_PORTS'(1) << pick_idx;
						gnt_idx <= pick_idx;
						state   <= ARB_HOLD;
					end
				end
				ARB_HOLD: begin
					if (msg_done) begin
						grant <= '0;
						ptr   <= gnt_idx + 2'd1;   // next port gets first look
						state <= ARB_SCAN;
					end
				end
				default: begin
					grant <= '0;
					state <= ARB_SCAN;
				end
			endcase
		end
	end

	a_grant_onehot: assert property (@(posedge fpu_clk) disable iff (reset)
		$onehot0(grant)) else $error("more than one port granted");

	// intake may only finish a message while a port owns the path
	a_done_in_hold: assert property (@(posedge fpu_clk) disable iff (reset)
		msg_done |-> (state == ARB_HOLD && grant != '0))
		else $error("msg_done without a granted port");

endmodule

// ==== testbench/tb_dma_path.sv ====
//////////////////////////////////////////////////////////////////////
// random traffic on all four ports checked against a per-port model
// dram_addr[39:32] and data[127:120] carry the port number
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dma_path import dma_path_pkg::*; ();

	// one expected wcc transfer
	typedef struct packed {
		logic         last;
		dma_cmd_t     cmd;
		logic [127:0] data;
	} wr_exp_t;

	logic                 fpu_clk = 1'b0;
	logic                 reset = 1'b1;
	logic [NUM_PORTS-1:0] dma_req = '0;
	logic [NUM_PORTS-1:0] dma_resp;
	fpu_wr_t              dma_write [NUM_PORTS] = '{default: '0};
	logic [NUM_PORTS-1:0] dma_write_ready;
	dma_cmd_t             rcc_cmd;
	logic                 rcc_valid;
	logic                 rcc_ready = 1'b0;
	dma_cmd_t             wcc_cmd;
	logic [127:0]         wcc_write_data;
	logic                 wcc_valid;
	logic                 wcc_ready = 1'b0;

	logic [127:0] beat_q [NUM_PORTS][$];   // beats each port still has to send
	int           beats_left [NUM_PORTS] = '{default: 0};
	dma_cmd_t     exp_rd [NUM_PORTS][$];
	wr_exp_t      exp_wr [NUM_PORTS][$];

	int checks = 0;
	int errors = 0;
	int chk_mark = 0;
	int err_mark = 0;
	int serial = 0;
	int budget = 100;   // watchdog limit in cycles that grows with traffic
	int rd_total = 0;
	int wr_total = 0;
	int rd_seen = 0;
	int wr_seen = 0;
	bit rr_mode = 1'b0;
	int rr_next = 0;
	bit wr_in_msg = 1'b0;
	int wr_port = 0;

	always #2 fpu_clk = ~fpu_clk;

	dma_path_top #(.MSG_FIFO_DEPTH(16), .RCC_FIFO_DEPTH(4)) uut (
		.fpu_clk         (fpu_clk),
		.reset           (reset),
		.dma_req         (dma_req),
		.dma_resp        (dma_resp),
		.dma_write       (dma_write),
		.dma_write_ready (dma_write_ready),
		.rcc_cmd         (rcc_cmd),
		.rcc_valid       (rcc_valid),
		.rcc_ready       (rcc_ready),
		.wcc_cmd         (wcc_cmd),
		.wcc_write_data  (wcc_write_data),
		.wcc_valid       (wcc_valid),
		.wcc_ready       (wcc_ready)
	);

	task automatic check_value(input string name, input logic [127:0] got,
	                           input logic [127:0] want);
		checks++;
		assert (got === want) else begin
			$display("FAILED %s: got %0h, expected %0h", name, got, want);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - chk_mark,
		         errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// message model that queues the beats and what must come out of them
	//////////////////////////////////////////////////////////////////////
	task automatic add_message(input int p, input logic [7:0] form, input int len);
		dma_hdr_t     hdr;
		dma_cmd_t     cmd;
		wr_exp_t      exp_beat;
		logic [127:0] word;
		int           nbeats;
		hdr.pad        = {16'($urandom), $urandom};
		hdr.msg_form   = msg_form_e'(form);
		hdr.length     = 16'(len);
		hdr.dpram_addr = 16'($urandom);
		hdr.dram_addr  = {8'(p), 16'(serial), 16'($urandom)};
		cmd.length     = hdr.length;
		cmd.dpram_addr = hdr.dpram_addr;
		cmd.dram_addr  = hdr.dram_addr;
		nbeats = (form == MSG_WRITE) ? len : 1;   // other forms are header only
		beat_q[p].push_back(hdr);
		if (form == MSG_READ) begin
			exp_rd[p].push_back(cmd);
			rd_total++;
		end
		for (int i = 1; i < nbeats; i++) begin
			word = {$urandom, $urandom, $urandom, $urandom};
			word[127:120] = 8'(p);
			word[119:104] = 16'(serial);
			word[103:96]  = 8'(i);
			beat_q[p].push_back(word);
			exp_beat.last = (i == nbeats - 1);
			exp_beat.cmd  = cmd;
			exp_beat.data = word;
			exp_wr[p].push_back(exp_beat);
			wr_total++;
		end
		serial++;
		budget += nbeats * 16 + 24;
	endtask

	// all beats sent and at least as many outputs seen as the model owes
	function automatic bit all_drained();
		bit done;
		done = (rd_seen >= rd_total) && (wr_seen >= wr_total);
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (beat_q[p].size() > 0)
				done = 1'b0;
		end
		return done;
	endfunction

	task automatic wait_drain();
		do
			@(posedge fpu_clk);
		while (!all_drained());
		repeat (20) @(posedge fpu_clk);   // catch stray outputs
	endtask

	//////////////////////////////////////////////////////////////////////
	// port drivers and sinks
	//////////////////////////////////////////////////////////////////////
	always @(posedge fpu_clk) begin : drive_ports
		dma_hdr_t     hdr;
		logic         v;
		logic [127:0] d;
		if (!reset) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (dma_write[p].valid && dma_write_ready[p]) begin
					void'(beat_q[p].pop_front());
					beats_left[p]--;
				end else if (dma_resp[p] && beats_left[p] == 0 && beat_q[p].size() > 0) begin
					hdr = dma_hdr_t'(beat_q[p][0]);   // granted so size up the message
					beats_left[p] = (hdr.msg_form == MSG_WRITE) ? int'(hdr.length) : 1;
				end
				v = (beats_left[p] > 0) && ($urandom % 4 != 0);   // random gaps
				d = (beat_q[p].size() > 0) ? beat_q[p][0] : '0;
				dma_write[p] <= {v, d};
				dma_req[p]   <= (beat_q[p].size() > 0);
			end
		end
	end

	always @(posedge fpu_clk) begin
		if (!reset) begin
			rcc_ready <= ($urandom % 4 != 0);
			wcc_ready <= ($urandom % 3 != 0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output checkers
	//////////////////////////////////////////////////////////////////////
	always @(posedge fpu_clk) begin : check_outputs
		int      port;
		bit      ok;
		wr_exp_t want_w;
		if (!reset && rcc_valid) begin
			rd_seen++;
			port = int'(rcc_cmd.dram_addr[39:32]);
			ok = (port < NUM_PORTS);
			if (ok)
				ok = (exp_rd[port].size() > 0);
			assert (ok) else begin
				$display("read command for port %0d arrived with none expected", port);
				errors++;
			end
			if (ok)
				check_value("rcc_cmd", 128'(rcc_cmd), 128'(exp_rd[port].pop_front()));
			if (rr_mode) begin
				assert (port == rr_next) else begin
					$display("read command from port %0d, port %0d was next in turn",
					         port, rr_next);
					errors++;
				end
				rr_next = (rr_next + 1) % NUM_PORTS;
			end
		end
		if (!reset && wcc_valid && wcc_ready) begin
			wr_seen++;
			port = int'(wcc_cmd.dram_addr[39:32]);
			if (wr_in_msg) begin
				assert (port == wr_port) else begin
					$display("write beat from port %0d inside a write from port %0d",
					         port, wr_port);
					errors++;
				end
			end
			ok = (port < NUM_PORTS);
			if (ok)
				ok = (exp_wr[port].size() > 0);
			assert (ok) else begin
				$display("write beat for port %0d arrived with none expected", port);
				errors++;
			end
			if (ok) begin
				want_w = exp_wr[port].pop_front();
				check_value("wcc_cmd", 128'(wcc_cmd), 128'(want_w.cmd));
				check_value("wcc_write_data", wcc_write_data, want_w.data);
				wr_in_msg = !want_w.last;
				wr_port   = port;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < budget) begin
			@(posedge fpu_clk);
			cycles++;
		end
		$display("timeout after %0d cycles, traffic did not drain", cycles);
		$display("Checks failed");
		$finish;
	end

	initial begin : main
		int nmsg;
		int r;
		void'($urandom(48));
		repeat (8) @(posedge fpu_clk);
		reset <= 1'b0;

		// no stimulus yet so everything must stay quiet
		repeat (12) begin
			@(posedge fpu_clk);
			check_value("dma_resp", 128'(dma_resp), '0);
			check_value("dma_write_ready", 128'(dma_write_ready), '0);
			check_value("rcc_valid", 128'(rcc_valid), '0);
			check_value("wcc_valid", 128'(wcc_valid), '0);
		end
		finish_test("idle after reset");

		rr_mode = 1'b1;
		rr_next = 0;
		for (int k = 0; k < 5; k++) begin
			for (int p = 0; p < NUM_PORTS; p++)
				add_message(p, MSG_READ, 1);
		end
		wait_drain();
		rr_mode = 1'b0;
		finish_test("round robin reads");

		for (int p = 0; p < NUM_PORTS; p++) begin
			nmsg = $urandom_range(4, 8);
			for (int m = 0; m < nmsg; m++) begin
				r = $urandom % 10;
				if (r < 4)
					add_message(p, MSG_READ, $urandom_range(1, 6));
				else if (r < 8)
					add_message(p, MSG_WRITE, $urandom_range(1, 6));
				else
					add_message(p, 8'($urandom_range(4, 255)), $urandom_range(1, 6));
			end
		end
		wait_drain();
		finish_test("random mixed traffic");

		check_value("rcc_count", 128'(rd_seen), 128'(rd_total));
		check_value("wcc_count", 128'(wr_seen), 128'(wr_total));
		for (int p = 0; p < NUM_PORTS; p++) begin
			checks++;
			assert (exp_rd[p].size() == 0 && exp_wr[p].size() == 0) else begin
				$display("port %0d still has %0d read commands and %0d write beats due",
				         p, exp_rd[p].size(), exp_wr[p].size());
				errors++;
			end
		end
		finish_test("end of run counts");
		$display("checks %0d, errors %0d, read commands %0d, write beats %0d",
		         checks, errors, rd_seen, wr_seen);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
